// ==== Bender.yml ====
package:
  name: ifu

dependencies: {}

sources:
  # shared package first
  - rtl/ifu_pkg.sv
  # leaf modules
  - rtl/ifu_bus_timer.sv
  - rtl/ifu_icache.sv
  - rtl/ifu_fetch_fsm.sv
  # fetch stage top level
  - rtl/ifu_top.sv
  # testbench
  - target: test
    files:
      - tests/tb_ifu_top.sv

// ==== files.f ====
rtl/ifu_pkg.sv
rtl/ifu_bus_timer.sv
rtl/ifu_icache.sv
rtl/ifu_fetch_fsm.sv
rtl/ifu_top.sv
tests/tb_ifu_top.sv

// ==== rtl/ifu_bus_timer.sv ====
`timescale 1ns/1ps

module ifu_bus_timer #(
  parameter int TIMEOUT_CYCLES = 64
) (
  input  logic clk,
  input  logic rst,

  input  logic start_i,
  input  logic stop_i,
  output logic expired_o
);

  localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);

  logic             running_q;
  logic [CNT_W-1:0] cnt_q;

  assign expired_o = running_q && !stop_i && (cnt_q == CNT_W'(TIMEOUT_CYCLES));

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      running_q <= 1'b0;
      cnt_q     <= '0;
    end
    else if (start_i)
    begin
      running_q <= 1'b1;
      cnt_q     <= CNT_W'(1);  // first waiting cycle
    end
    else if (stop_i || expired_o)
    begin
      running_q <= 1'b0;
      cnt_q     <= '0;
    end
    else if (running_q)
      cnt_q <= cnt_q + 1'b1;
  end

  // expiry ends the wait, no new read starts in the same cycle
  a_expire_running: assert property (@(posedge clk) disable iff (rst)
    expired_o |-> running_q ##1 !running_q);

endmodule

// ==== rtl/ifu_fetch_fsm.sv ====
`timescale 1ns/1ps

module ifu_fetch_fsm (
  input  logic                clk,
  input  logic                rst,

  input  logic                req_valid_i,
  input  ifu_pkg::fetch_req_t req_i,
  output logic                req_ready_o,

  output logic                resp_valid_o,
  output ifu_pkg::fetch_resp_t resp_o,
  input  logic                resp_ready_i,

  output logic                bus_arvalid_o,
  output ifu_pkg::addr_t      bus_araddr_o,
  input  logic                bus_rvalid_i,
  input  ifu_pkg::inst_t      bus_rdata_i,

  output ifu_pkg::addr_t      lookup_addr_o,
  input  logic                hit_i,
  input  ifu_pkg::inst_t      hit_inst_i,
  output logic                fill_en_o,
  output ifu_pkg::inst_t      fill_inst_o,

  output logic                timer_start_o,
  output logic                timer_stop_o,
  input  logic                expired_i
);
  import ifu_pkg::*;

  fetch_state_e state_q, state_d;
  addr_t        pc_q;
  fetch_resp_t  resp_q;
  logic         arvalid_q;
  logic         rdata_ok;

  assign req_ready_o   = (state_q == IDLE);
  assign resp_valid_o  = (state_q == RESP);
  assign resp_o        = resp_q;

  assign lookup_addr_o = pc_q;
  assign bus_araddr_o  = {pc_q[ADDR_W-1:2], 2'b00};  // word aligned
  assign bus_arvalid_o = arvalid_q;

  // late rvalid outside WAIT_MEM is dropped here
  assign rdata_ok      = (state_q == WAIT_MEM) && bus_rvalid_i;

  assign fill_en_o     = rdata_ok;
  assign fill_inst_o   = bus_rdata_i;
  assign timer_start_o = arvalid_q;
  assign timer_stop_o  = rdata_ok;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:     if (req_valid_i) state_d = LOOKUP;
      LOOKUP:   state_d = hit_i ? RESP : WAIT_MEM;
      WAIT_MEM: if (rdata_ok || expired_i) state_d = RESP;
      RESP:     if (resp_ready_i) state_d = IDLE;
      default:  state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q   <= IDLE;
      arvalid_q <= 1'b0;
    end
    else
    begin
      state_q   <= state_d;
      arvalid_q <= (state_q == LOOKUP) && !hit_i;  // strobe in first WAIT_MEM cycle
    end
  end

  always_ff @(posedge clk)
  begin
    if (req_valid_i && req_ready_o)
      pc_q <= req_i.pc;

    if (state_q == LOOKUP && hit_i)
    begin
      resp_q.pc   <= pc_q;
      resp_q.inst <= hit_inst_i;
      resp_q.err  <= 1'b0;
    end
    else if (rdata_ok)
    begin
      resp_q.pc   <= pc_q;
      resp_q.inst <= bus_rdata_i;
      resp_q.err  <= 1'b0;
    end
    else if (state_q == WAIT_MEM && expired_i)
    begin
      resp_q.pc   <= pc_q;
      resp_q.inst <= '0;
      resp_q.err  <= 1'b1;
    end
  end

  a_arvalid_strobe: assert property (@(posedge clk) disable iff (rst)
    bus_arvalid_o |=> !bus_arvalid_o);

  // held response must not change under back-pressure
  a_resp_stable: assert property (@(posedge clk) disable iff (rst)
    resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_o));

endmodule

// ==== rtl/ifu_icache.sv ====
`timescale 1ns/1ps

module ifu_icache #(
  parameter int IDX_W = 8
) (
  input  logic           clk,
  input  logic           rst,

  input  ifu_pkg::addr_t lookup_addr_i,
  output logic           hit_o,
  output ifu_pkg::inst_t hit_inst_o,

  input  logic           fill_en_i,
  input  ifu_pkg::inst_t fill_inst_i
);
  import ifu_pkg::*;

  localparam int TAG_W = ADDR_W - IDX_W - 2;
  localparam int LINES = 1 << IDX_W;

  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [IDX_W-1:0] idx_t;

  idx_t             idx;
  tag_t             tag;

  inst_t            data_q [LINES];
  tag_t             tag_q  [LINES];
  logic [LINES-1:0] valid_q;

  // byte offset bits are not part of the index
  assign idx = lookup_addr_i[IDX_W+1:2];
  assign tag = lookup_addr_i[ADDR_W-1:IDX_W+2];

  assign hit_o      = valid_q[idx] && (tag_q[idx] == tag);
  assign hit_inst_o = data_q[idx];

  always_ff @(posedge clk)
  begin
    if (rst)
      valid_q <= '0;
    else if (fill_en_i)
      valid_q[idx] <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (fill_en_i)
    begin
      data_q[idx] <= fill_inst_i;
      tag_q[idx]  <= tag;  // a conflicting line is simply replaced
    end
  end

  // the fetch fsm only refills after a miss on the same address
  a_no_fill_on_hit: assert property (@(posedge clk) disable iff (rst)
    fill_en_i |-> !hit_o);

endmodule

// ==== rtl/ifu_pkg.sv ====
package ifu_pkg;

  // byte address and instruction widths
  localparam int ADDR_W = 32;
  localparam int INST_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [INST_W-1:0] inst_t;

  // request from the upstream pipeline
  typedef struct packed {
    addr_t pc;
  } fetch_req_t;

  // response to the downstream pipeline
  typedef struct packed {
    addr_t pc;
    inst_t inst;
    logic  err;  // bus read timed out, inst is not valid
  } fetch_resp_t;

  // fetch sequencing
  typedef enum logic [1:0] {
    IDLE,      // waiting for a request
    LOOKUP,    // cache tag compare
    WAIT_MEM,  // miss, bus read outstanding
    RESP       // response held until downstream takes it
  } fetch_state_e;

endpackage

// ==== rtl/ifu_top.sv ====
`timescale 1ns/1ps

module ifu_top #(
  parameter int IDX_W          = 8,
  parameter int TIMEOUT_CYCLES = 64
) (
  input  logic                 clk,
  input  logic                 rst,

  input  logic                 req_valid_i,
  input  ifu_pkg::fetch_req_t  req_i,
  output logic                 req_ready_o,

  output logic                 resp_valid_o,
  output ifu_pkg::fetch_resp_t resp_o,
  input  logic                 resp_ready_i,

  output logic                 bus_arvalid_o,
  output ifu_pkg::addr_t       bus_araddr_o,
  input  logic                 bus_rvalid_i,
  input  ifu_pkg::inst_t       bus_rdata_i
);
  import ifu_pkg::*;

  addr_t lookup_addr;
  logic  hit;
  inst_t hit_inst;
  logic  fill_en;
  inst_t fill_inst;
  logic  timer_start;
  logic  timer_stop;
  logic  expired;

  ifu_fetch_fsm fsm_i (
    .clk           (clk),
    .rst           (rst),
    .req_valid_i   (req_valid_i),
    .req_i         (req_i),
    .req_ready_o   (req_ready_o),
    .resp_valid_o  (resp_valid_o),
    .resp_o        (resp_o),
    .resp_ready_i  (resp_ready_i),
    .bus_arvalid_o (bus_arvalid_o),
    .bus_araddr_o  (bus_araddr_o),
    .bus_rvalid_i  (bus_rvalid_i),
    .bus_rdata_i   (bus_rdata_i),
    .lookup_addr_o (lookup_addr),
    .hit_i         (hit),
    .hit_inst_i    (hit_inst),
    .fill_en_o     (fill_en),
    .fill_inst_o   (fill_inst),
    .timer_start_o (timer_start),
    .timer_stop_o  (timer_stop),
    .expired_i     (expired)
  );

  ifu_icache #(
    .IDX_W (IDX_W)
  ) icache_i (
    .clk           (clk),
    .rst           (rst),
    .lookup_addr_i (lookup_addr),
    .hit_o         (hit),
    .hit_inst_o    (hit_inst),
    .fill_en_i     (fill_en),
    .fill_inst_i   (fill_inst)
  );

  ifu_bus_timer #(
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
  ) timer_i (
    .clk       (clk),
    .rst       (rst),
    .start_i   (timer_start),
    .stop_i    (timer_stop),
    .expired_o (expired)
  );

endmodule

// ==== tests/tb_ifu_top.sv ====
`timescale 1ns/1ps

module tb_ifu_top;
  import ifu_pkg::*;

  localparam int IDX_W      = 4;
  localparam int TIMEOUT    = 16;
  localparam int MAX_CYCLES = 4000;  // 40 fetches at about 25 cycles, plus margin
  localparam int RESP_WAIT  = 40;
  localparam int LINES      = 1 << IDX_W;

  logic        clk;
  logic        rst;
  logic        req_valid_i;
  fetch_req_t  req_i;
  logic        req_ready_o;
  logic        resp_valid_o;
  fetch_resp_t resp_o;
  logic        resp_ready_i;
  logic        bus_arvalid_o;
  addr_t       bus_araddr_o;
  logic        bus_rvalid_i;
  inst_t       bus_rdata_i;

  addr_t       cur_pc;
  addr_t       silent_q [$];       // bus model does not answer these
  addr_t       line_addr [LINES];  // word address expected in each line
  logic        line_valid [LINES];
  int          delay_tab [64];
  int          answer_cnt = 0;
  int          strobe_cnt;
  int          cycle_cnt;
  int          seed_val;

  ifu_top #(
    .IDX_W          (IDX_W),
    .TIMEOUT_CYCLES (TIMEOUT)
  ) dut_i (
    .clk           (clk),
    .rst           (rst),
    .req_valid_i   (req_valid_i),
    .req_i         (req_i),
    .req_ready_o   (req_ready_o),
    .resp_valid_o  (resp_valid_o),
    .resp_o        (resp_o),
    .resp_ready_i  (resp_ready_i),
    .bus_arvalid_o (bus_arvalid_o),
    .bus_araddr_o  (bus_araddr_o),
    .bus_rvalid_i  (bus_rvalid_i),
    .bus_rdata_i   (bus_rdata_i)
  );

  always #50 clk = ~clk;

  function automatic addr_t word_addr(input addr_t a);
    return {a[ADDR_W-1:2], 2'b00};
  endfunction

  function automatic inst_t mem_word(input addr_t a);
    return word_addr(a) ^ 32'hA5A5_0000;
  endfunction

  // direct mapped, index taken above the byte bits
  function automatic logic expect_hit(input addr_t a);
    logic [IDX_W-1:0] idx;
    idx = a[IDX_W+1:2];
    return line_valid[idx] && (line_addr[idx] == word_addr(a));
  endfunction

  function automatic logic is_silent(input addr_t a);
    foreach (silent_q[i])
      if (silent_q[i] == word_addr(a))
        return 1'b1;
    return 1'b0;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [127:0] exp,
                             input logic [127:0] act);
    assert (act === exp)
    else
      stop_on_error($sformatf("ERROR at %0t: %s expected %0h, got %0h",
                              $time, name, exp, act));
  endtask

  a_reset_idle: assert property (@(posedge clk)
    $fell(rst) |-> req_ready_o && !resp_valid_o && !bus_arvalid_o)
    else stop_on_error($sformatf(
      "ERROR at %0t: req_ready_o/resp_valid_o/bus_arvalid_o expected 1/0/0, got %b/%b/%b",
      $time, req_ready_o, resp_valid_o, bus_arvalid_o));

  a_hit_latency: assert property (@(posedge clk) disable iff (rst)
    req_valid_i && req_ready_o && expect_hit(req_i.pc)
      |=> !resp_valid_o ##1 resp_valid_o && !bus_arvalid_o)
    else stop_on_error($sformatf(
      "ERROR at %0t: resp_valid_o/bus_arvalid_o on hit expected 1/0, got %b/%b",
      $time, resp_valid_o, bus_arvalid_o));

  a_miss_strobe: assert property (@(posedge clk) disable iff (rst)
    req_valid_i && req_ready_o && !expect_hit(req_i.pc) |-> ##2 bus_arvalid_o)
    else stop_on_error($sformatf("ERROR at %0t: bus_arvalid_o on miss expected 1, got %b",
                                 $time, bus_arvalid_o));

  a_araddr: assert property (@(posedge clk) disable iff (rst)
    bus_arvalid_o |-> bus_araddr_o == word_addr(cur_pc))
    else stop_on_error($sformatf("ERROR at %0t: bus_araddr_o expected %h, got %h",
                                 $time, word_addr(cur_pc), bus_araddr_o));

  a_back_pressure: assert property (@(posedge clk) disable iff (rst)
    resp_valid_o && !resp_ready_i
      |=> resp_valid_o && $stable(resp_o) && !req_ready_o && !bus_arvalid_o)
    else stop_on_error($sformatf(
      "ERROR at %0t: resp_valid_o/req_ready_o/bus_arvalid_o held expected 1/0/0, got %b/%b/%b",
      $time, resp_valid_o, req_ready_o, bus_arvalid_o));

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (!rst && bus_arvalid_o)
      strobe_cnt <= strobe_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES)
      stop_on_error($sformatf("run hung, still going after %0d cycles", MAX_CYCLES));
  end

  // bus memory model, one read outstanding at most
  initial
  begin : memory_model
    addr_t addr;
    forever
    begin
      @(posedge clk);
      #10;
      if (!rst && bus_arvalid_o && !is_silent(bus_araddr_o))
      begin
        addr = bus_araddr_o;
        repeat (delay_tab[answer_cnt % 64]) @(posedge clk);
        answer_cnt++;
        #10;
        bus_rvalid_i = 1'b1;
        bus_rdata_i  = mem_word(addr);
        @(posedge clk);
        #10;
        bus_rvalid_i = 1'b0;
        bus_rdata_i  = '0;
      end
    end
  end

  task automatic fetch(input addr_t pc, input int hold);
    logic             exp_hit;
    logic             exp_err;
    int               strobes_before;
    int               waited;
    fetch_resp_t      held;
    logic [IDX_W-1:0] idx;

    exp_hit        = expect_hit(pc);
    exp_err        = !exp_hit && is_silent(pc);
    strobes_before = strobe_cnt;
    cur_pc         = pc;
    req_i.pc       = pc;
    req_valid_i    = 1'b1;
    resp_ready_i   = (hold == 0);
    @(posedge clk);  // accept edge, stage is idle here
    #10;
    req_valid_i = 1'b0;
    waited      = 0;
    while (!resp_valid_o && waited < RESP_WAIT)
    begin
      @(posedge clk);
      #10;
      waited++;
    end
    assert (resp_valid_o)
    else
      stop_on_error($sformatf("no response to fetch of pc %h within %0d cycles", pc, RESP_WAIT));

    check_value("resp_o.pc", pc, resp_o.pc);
    check_value("resp_o.err", exp_err, resp_o.err);
    if (!exp_err)
      check_value("resp_o.inst", mem_word(pc), resp_o.inst);

    held = resp_o;
    repeat (hold)
    begin
      @(posedge clk);
      #10;
      check_value("resp_valid_o", 1'b1, resp_valid_o);
      check_value("resp_o", held, resp_o);
      check_value("req_ready_o", 1'b0, req_ready_o);
    end
    check_value("bus_arvalid_o strobes", exp_hit ? 0 : 1, strobe_cnt - strobes_before);

    resp_ready_i = 1'b1;
    @(posedge clk);  // response transfer
    #10;
    check_value("resp_valid_o", 1'b0, resp_valid_o);
    if (!exp_err)
    begin
      idx             = pc[IDX_W+1:2];
      line_valid[idx] = 1'b1;
      line_addr[idx]  = word_addr(pc);
    end
  endtask

  initial
  begin : stimulus
    addr_t pc;
    seed_val     = $urandom(32'h1375);
    clk          = 1'b0;
    rst          = 1'b1;
    req_valid_i  = 1'b0;
    req_i        = '0;
    resp_ready_i = 1'b1;
    bus_rvalid_i = 1'b0;
    bus_rdata_i  = '0;
    cur_pc       = '0;
    strobe_cnt   = 0;
    cycle_cnt    = 0;
    for (int i = 0; i < LINES; i++)
    begin
      line_valid[i] = 1'b0;
      line_addr[i]  = '0;
    end
    for (int i = 0; i < 64; i++)
      delay_tab[i] = $urandom_range(1, 6);

    repeat (2) @(posedge clk);
    #10;
    rst = 1'b0;
    check_value("req_ready_o", 1'b1, req_ready_o);
    check_value("resp_valid_o", 1'b0, resp_valid_o);
    check_value("bus_arvalid_o", 1'b0, bus_arvalid_o);

    fetch(32'h0000_1004, 0);  // cold miss
    fetch(32'h0000_1004, 0);
    fetch(32'h0000_1004, 0);
    fetch(32'h0000_7a0e, 0);  // byte bits set

    // index 2 with two different tags
    repeat (3)
    begin
      fetch(32'h0000_2008, 0);
      fetch(32'h0003_4008, 0);
    end

    fetch(32'h0000_1004, 5);
    fetch(32'h0000_5c10, 4);

    silent_q.push_back(32'h0000_9f00);
    fetch(32'h0000_9f00, 0);
    silent_q.delete();
    fetch(32'h0000_9f00, 0);  // line was never filled, so this misses
    fetch(32'h0000_9f00, 0);

    repeat (20)
    begin
      pc = ($urandom_range(0, 2) << 6) | ($urandom_range(0, 15) << 2);
      fetch(pc, $urandom_range(0, 2));
    end

    repeat (2) @(posedge clk);
    $display("Everything OK");
    $finish;
  end

endmodule
